/* core_pkg.sv */
package core_pkg;

    // datapath widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int CSR_AW = 14;
    localparam int OPC_W  = 6;
    localparam int IMM_W  = 12;

    // instruction field positions
    localparam int OPC_LSB = 26;
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int IMM_LSB = 10;
    localparam int CSR_LSB = 10;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP     = 6'h00,
        OP_ADD     = 6'h01,
        OP_SUB     = 6'h02,
        OP_AND     = 6'h03,
        OP_OR      = 6'h04,
        OP_XOR     = 6'h05,
        OP_SLT     = 6'h06,
        OP_SLL     = 6'h07,
        OP_SRL     = 6'h08,
        OP_ADDI    = 6'h09,
        OP_CSRRD   = 6'h0a,
        OP_CSRWR   = 6'h0b,
        OP_CSRXCHG = 6'h0c
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        CSR_NONE, CSR_RD, CSR_WR, CSR_XCHG
    } csr_op_e;

    // csr numbers, reset values and writable bits
    localparam logic [CSR_AW-1:0] CSR_CRMD      = 14'h0000;
    localparam logic [CSR_AW-1:0] CSR_PRMD      = 14'h0001;
    localparam logic [CSR_AW-1:0] CSR_ERA       = 14'h0006;
    localparam logic [CSR_AW-1:0] CSR_SAVE_BASE = 14'h0030;

    localparam logic [XLEN-1:0] CSR_CRMD_RST   = 32'h0000_0008;
    localparam logic [XLEN-1:0] CSR_CRMD_WMASK = 32'h0000_01ff;
    localparam logic [XLEN-1:0] CSR_PRMD_RST   = 32'h0000_0000;
    localparam logic [XLEN-1:0] CSR_PRMD_WMASK = 32'h0000_0007;
    localparam logic [XLEN-1:0] CSR_ERA_RST    = 32'h0000_0000;
    localparam logic [XLEN-1:0] CSR_ERA_WMASK  = 32'hffff_ffff;
    localparam logic [XLEN-1:0] CSR_SAVE_RST   = 32'h0000_0000;
    localparam logic [XLEN-1:0] CSR_SAVE_WMASK = 32'hffff_ffff;

endpackage

/* alu_exec.sv */
`timescale 1ns/100ps

module alu_exec
    import core_pkg::*;
(
    input  alu_op_e         ex_alu_op,
    input  logic [XLEN-1:0] ex_src1,
    input  logic [XLEN-1:0] ex_src2,
    output logic [XLEN-1:0] alu_result
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic            lt_signed;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign shamt     = ex_src2[SHW-1:0];
    assign sum       = ex_src1 + ex_src2;
    assign diff      = ex_src1 - ex_src2;
    assign lt_signed = $signed(ex_src1) < $signed(ex_src2);

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = sum;
            ALU_SUB: alu_result = diff;
            ALU_AND: alu_result = ex_src1 & ex_src2;
            ALU_OR:  alu_result = ex_src1 | ex_src2;
            ALU_XOR: alu_result = ex_src1 ^ ex_src2;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLL: alu_result = ex_src1 << shamt;
            ALU_SRL: alu_result = ex_src1 >> shamt;
            default: alu_result = sum;
        endcase
    end

endmodule

/* csr_file.sv */
`timescale 1ns/100ps

module csr_file
    import core_pkg::*;
#(
    parameter int NUM_SAVE = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid,
    input  csr_op_e           ex_csr_op,
    input  logic [CSR_AW-1:0] ex_csr_num,
    input  logic [XLEN-1:0]   ex_src1,
    input  logic [XLEN-1:0]   ex_src2,
    output logic [XLEN-1:0]   csr_rdata
);

    logic [XLEN-1:0] crmd;
    logic [XLEN-1:0] prmd;
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] save [NUM_SAVE];
    logic [XLEN-1:0] reg_wmask;
    logic [XLEN-1:0] wr_mask;
    logic [XLEN-1:0] csr_wdata;
    logic            csr_wr_req;
    logic            csr_commit;

    // read mux and writable bits of the selected csr
    always_comb begin
        csr_rdata = '0;
        reg_wmask = '0;
        case (ex_csr_num)
            CSR_CRMD: begin
                csr_rdata = crmd;
                reg_wmask = CSR_CRMD_WMASK;
            end
            CSR_PRMD: begin
                csr_rdata = prmd;
                reg_wmask = CSR_PRMD_WMASK;
            end
            CSR_ERA: begin
                csr_rdata = era;
                reg_wmask = CSR_ERA_WMASK;
            end
            default: ;
        endcase
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (ex_csr_num == CSR_AW'(CSR_SAVE_BASE + i)) begin
                csr_rdata = save[i];
                reg_wmask = CSR_SAVE_WMASK;
            end
        end
    end

    // exchange narrows the mask with rj
    assign wr_mask    = reg_wmask & ((ex_csr_op == CSR_XCHG) ? ex_src1 : '1);
    assign csr_wdata  = (csr_rdata & ~wr_mask) | (ex_src2 & wr_mask);
    assign csr_wr_req = (ex_csr_op == CSR_WR) || (ex_csr_op == CSR_XCHG);
    assign csr_commit = csr_wr_req && ex_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= CSR_CRMD_RST;
            prmd <= CSR_PRMD_RST;
            era  <= CSR_ERA_RST;
            for (int i = 0; i < NUM_SAVE; i++)
                save[i] <= CSR_SAVE_RST;
        end else if (csr_commit) begin
            case (ex_csr_num)
                CSR_CRMD: crmd <= csr_wdata;
                CSR_PRMD: prmd <= csr_wdata;
                CSR_ERA:  era  <= csr_wdata;
                default: ;
            endcase
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (ex_csr_num == CSR_AW'(CSR_SAVE_BASE + i))
                    save[i] <= csr_wdata;
            end
        end
    end

    // issue clears the csr op on empty slots
    a_wr_needs_valid: assert property (@(posedge clk) disable iff (rst)
        csr_wr_req |-> ex_valid);

endmodule

/* issue_stage.sv */
`timescale 1ns/100ps

module issue_stage
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    input  logic [XLEN-1:0]   inst_pc,
    input  logic [XLEN-1:0]   rf_rdata1,
    input  logic [XLEN-1:0]   rf_rdata2,
    input  logic [XLEN-1:0]   ex_result,
    input  logic              wb_rf_we,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_wdata,
    output logic [REG_AW-1:0] rf_raddr1,
    output logic [REG_AW-1:0] rf_raddr2,
    output logic              ex_valid,
    output logic [XLEN-1:0]   ex_pc,
    output alu_op_e           ex_alu_op,
    output csr_op_e           ex_csr_op,
    output logic [CSR_AW-1:0] ex_csr_num,
    output logic [XLEN-1:0]   ex_src1,
    output logic [XLEN-1:0]   ex_src2,
    output logic [REG_AW-1:0] ex_rd,
    output logic              ex_rf_we
);

    opcode_e           opcode;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk;
    logic [XLEN-1:0]   imm_sext;
    alu_op_e           alu_op;
    csr_op_e           csr_op;
    logic              writes_rd;
    logic              use_imm;
    logic              rd_is_src;
    logic              rf_we;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;

    assign opcode   = opcode_e'(inst[OPC_LSB +: OPC_W]);
    assign rd       = inst[RD_LSB +: REG_AW];
    assign rj       = inst[RJ_LSB +: REG_AW];
    assign rk       = inst[RK_LSB +: REG_AW];
    assign imm_sext = {{(XLEN-IMM_W){inst[IMM_LSB+IMM_W-1]}}, inst[IMM_LSB +: IMM_W]};

    always_comb begin
        alu_op    = ALU_ADD;
        csr_op    = CSR_NONE;
        writes_rd = 1'b1;
        use_imm   = 1'b0;
        rd_is_src = 1'b0;
        case (opcode)
            OP_ADD:     alu_op = ALU_ADD;
            OP_SUB:     alu_op = ALU_SUB;
            OP_AND:     alu_op = ALU_AND;
            OP_OR:      alu_op = ALU_OR;
            OP_XOR:     alu_op = ALU_XOR;
            OP_SLT:     alu_op = ALU_SLT;
            OP_SLL:     alu_op = ALU_SLL;
            OP_SRL:     alu_op = ALU_SRL;
            OP_ADDI:    use_imm = 1'b1;
            OP_CSRRD:   csr_op = CSR_RD;
            OP_CSRWR: begin
                csr_op    = CSR_WR;
                rd_is_src = 1'b1;
            end
            OP_CSRXCHG: begin
                csr_op    = CSR_XCHG;
                rd_is_src = 1'b1;
            end
            // nop and undefined codes
            default:    writes_rd = 1'b0;
        endcase
    end

    assign rf_we = writes_rd && (rd != '0);

    // csr writes take their data from the rd register
    assign rf_raddr1 = rj;
    assign rf_raddr2 = rd_is_src ? rd : rk;

    // execute result first, then writeback, then the array
    function automatic logic [XLEN-1:0] fwd_sel(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   arr_data,
        input logic              ex_hit_we,
        input logic [REG_AW-1:0] ex_hit_rd,
        input logic [XLEN-1:0]   ex_data,
        input logic              wb_hit_we,
        input logic [REG_AW-1:0] wb_hit_rd,
        input logic [XLEN-1:0]   wb_data
    );
        if (addr == '0)
            return '0;
        else if (ex_hit_we && ex_hit_rd == addr)
            return ex_data;
        else if (wb_hit_we && wb_hit_rd == addr)
            return wb_data;
        else
            return arr_data;
    endfunction

    assign op1 = fwd_sel(rf_raddr1, rf_rdata1, ex_rf_we, ex_rd, ex_result,
                         wb_rf_we, wb_rd, wb_wdata);
    assign op2 = fwd_sel(rf_raddr2, rf_rdata2, ex_rf_we, ex_rd, ex_result,
                         wb_rf_we, wb_rd, wb_wdata);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            ex_rf_we  <= 1'b0;
            ex_csr_op <= CSR_NONE;
        end else begin
            ex_valid  <= inst_valid;
            ex_rf_we  <= inst_valid && rf_we;
            ex_csr_op <= inst_valid ? csr_op : CSR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= inst_pc;
        ex_alu_op  <= alu_op;
        ex_csr_num <= inst[CSR_LSB +: CSR_AW];
        ex_src1    <= op1;
        ex_src2    <= use_imm ? imm_sext : op2;
        ex_rd      <= rd;
    end

endmodule

/* writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid,
    input  logic [XLEN-1:0]   ex_pc,
    input  logic [REG_AW-1:0] ex_rd,
    input  logic              ex_rf_we,
    input  csr_op_e           ex_csr_op,
    input  logic [XLEN-1:0]   alu_result,
    input  logic [XLEN-1:0]   csr_rdata,
    input  logic [REG_AW-1:0] rf_raddr1,
    input  logic [REG_AW-1:0] rf_raddr2,
    output logic [XLEN-1:0]   ex_result,
    output logic              wb_rf_we,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]   wb_wdata,
    output logic [XLEN-1:0]   rf_rdata1,
    output logic [XLEN-1:0]   rf_rdata2,
    output logic              debug_wb_rf_we,
    output logic [XLEN-1:0]   debug_wb_pc,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]   debug_wb_rf_wdata
);

    localparam int NUM_REGS = 1 << REG_AW;

    logic [XLEN-1:0] wb_pc;
    logic [XLEN-1:0] rf [NUM_REGS];

    // csr ops return the old csr value
    assign ex_result = (ex_csr_op != CSR_NONE) ? csr_rdata : alu_result;

    always_ff @(posedge clk) begin
        if (rst)
            wb_rf_we <= 1'b0;
        else
            wb_rf_we <= ex_valid && ex_rf_we;
    end

    always_ff @(posedge clk) begin
        wb_pc    <= ex_pc;
        wb_rd    <= ex_rd;
        wb_wdata <= ex_result;
    end

    // register array, r0 never written since decode clears its enable
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                rf[i] <= '0;
        end else if (wb_rf_we) begin
            rf[wb_rd] <= wb_wdata;
        end
    end

    assign rf_rdata1 = rf[rf_raddr1];
    assign rf_rdata2 = rf[rf_raddr2];

    assign debug_wb_rf_we    = wb_rf_we;
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wnum  = wb_rd;
    assign debug_wb_rf_wdata = wb_wdata;

    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        ex_rf_we |-> (ex_rd != '0));

    a_debug_known: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_we |-> !$isunknown({debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata}));

endmodule

/* mini_core_top.sv */
`timescale 1ns/100ps

module mini_core_top
    import core_pkg::*;
#(
    parameter int NUM_SAVE = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    input  logic [XLEN-1:0]   inst_pc,
    output logic              debug_wb_rf_we,
    output logic [XLEN-1:0]   debug_wb_pc,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]   debug_wb_rf_wdata
);

    // execute register
    logic              ex_valid;
    logic [XLEN-1:0]   ex_pc;
    alu_op_e           ex_alu_op;
    csr_op_e           ex_csr_op;
    logic [CSR_AW-1:0] ex_csr_num;
    logic [XLEN-1:0]   ex_src1;
    logic [XLEN-1:0]   ex_src2;
    logic [REG_AW-1:0] ex_rd;
    logic              ex_rf_we;

    // execute results and forwarding
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   csr_rdata;
    logic [XLEN-1:0]   ex_result;
    logic              wb_rf_we;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_wdata;

    // register file read ports
    logic [REG_AW-1:0] rf_raddr1;
    logic [REG_AW-1:0] rf_raddr2;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;

    issue_stage u_issue (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_result  (ex_result),
        .wb_rf_we   (wb_rf_we),
        .wb_rd      (wb_rd),
        .wb_wdata   (wb_wdata),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .ex_valid   (ex_valid),
        .ex_pc      (ex_pc),
        .ex_alu_op  (ex_alu_op),
        .ex_csr_op  (ex_csr_op),
        .ex_csr_num (ex_csr_num),
        .ex_src1    (ex_src1),
        .ex_src2    (ex_src2),
        .ex_rd      (ex_rd),
        .ex_rf_we   (ex_rf_we)
    );

    alu_exec u_alu (
        .ex_alu_op  (ex_alu_op),
        .ex_src1    (ex_src1),
        .ex_src2    (ex_src2),
        .alu_result (alu_result)
    );

    csr_file #(
        .NUM_SAVE (NUM_SAVE)
    ) u_csr (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_csr_op  (ex_csr_op),
        .ex_csr_num (ex_csr_num),
        .ex_src1    (ex_src1),
        .ex_src2    (ex_src2),
        .csr_rdata  (csr_rdata)
    );

    writeback_stage u_wb (
        .clk               (clk),
        .rst               (rst),
        .ex_valid          (ex_valid),
        .ex_pc             (ex_pc),
        .ex_rd             (ex_rd),
        .ex_rf_we          (ex_rf_we),
        .ex_csr_op         (ex_csr_op),
        .alu_result        (alu_result),
        .csr_rdata         (csr_rdata),
        .rf_raddr1         (rf_raddr1),
        .rf_raddr2         (rf_raddr2),
        .ex_result         (ex_result),
        .wb_rf_we          (wb_rf_we),
        .wb_rd             (wb_rd),
        .wb_wdata          (wb_wdata),
        .rf_rdata1         (rf_rdata1),
        .rf_rdata2         (rf_rdata2),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* core_checker.sv */
`timescale 1ns/100ps

module core_checker
    import core_pkg::*;
#(
    parameter int NUM_SAVE = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    input  logic [XLEN-1:0]   inst_pc,
    input  logic              debug_wb_rf_we,
    input  logic [XLEN-1:0]   debug_wb_pc,
    input  logic [REG_AW-1:0] debug_wb_rf_wnum,
    input  logic [XLEN-1:0]   debug_wb_rf_wdata,
    output int                errors,
    output int                writes,
    output int                pending
);

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] num;
        logic [XLEN-1:0]   data;
        int                edge_no;
    } exp_t;

    logic [XLEN-1:0] regs [32];
    // crmd, prmd, era, then the scratch csrs
    logic [XLEN-1:0] csrs [3+NUM_SAVE];
    exp_t            exp_q [$];
    int              err_cnt = 0;
    int              wr_cnt = 0;
    int              depth = 0;
    int              edge_cnt = 0;

    assign errors  = err_cnt;
    assign writes  = wr_cnt;
    assign pending = depth;

    function automatic int csr_slot(input logic [CSR_AW-1:0] num);
        if (num == CSR_CRMD)
            return 0;
        if (num == CSR_PRMD)
            return 1;
        if (num == CSR_ERA)
            return 2;
        if (num >= CSR_SAVE_BASE && int'(num - CSR_SAVE_BASE) < NUM_SAVE)
            return 3 + int'(num - CSR_SAVE_BASE);
        return -1;
    endfunction

    function automatic logic [XLEN-1:0] wmask_of(input int slot);
        case (slot)
            0:       return CSR_CRMD_WMASK;
            1:       return CSR_PRMD_WMASK;
            2:       return CSR_ERA_WMASK;
            default: return CSR_SAVE_WMASK;
        endcase
    endfunction

    task automatic reset_model();
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        csrs[0] = CSR_CRMD_RST;
        csrs[1] = CSR_PRMD_RST;
        csrs[2] = CSR_ERA_RST;
        for (int i = 3; i < 3 + NUM_SAVE; i++)
            csrs[i] = CSR_SAVE_RST;
        exp_q.delete();
        edge_cnt = 0;
    endtask

    task automatic compare_field(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_debug();
        exp_t head;
        if (debug_wb_rf_we === 1'b1) begin
            wr_cnt++;
            if (exp_q.size() == 0) begin
                $display("t=%0t write strobe to r%0d with no write expected",
                         $time, debug_wb_rf_wnum);
                err_cnt++;
            end else begin
                head = exp_q.pop_front();
                compare_field("debug_wb_pc", debug_wb_pc, head.pc);
                compare_field("debug_wb_rf_wnum", XLEN'(debug_wb_rf_wnum), XLEN'(head.num));
                compare_field("debug_wb_rf_wdata", debug_wb_rf_wdata, head.data);
                if (edge_cnt != head.edge_no + 2) begin
                    $display("t=%0t write of pc %h came %0d edges after issue instead of 2",
                             $time, head.pc, edge_cnt - head.edge_no);
                    err_cnt++;
                end
            end
        end else if (debug_wb_rf_we !== 1'b0) begin
            $display("t=%0t debug_wb_rf_we is unknown", $time);
            err_cnt++;
        end else if (exp_q.size() != 0 && exp_q[0].edge_no + 2 <= edge_cnt) begin
            head = exp_q.pop_front();
            $display("t=%0t write of pc %h to r%0d never showed up", $time, head.pc, head.num);
            err_cnt++;
        end
    endtask

    // architectural effect of one accepted instruction
    task automatic apply_inst(input logic [XLEN-1:0] word, input logic [XLEN-1:0] pc);
        logic [OPC_W-1:0]  opc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   res;
        logic [XLEN-1:0]   mask;
        logic              we;
        int                slot;
        exp_t              item;
        opc  = word[OPC_LSB +: OPC_W];
        rd   = word[RD_LSB +: REG_AW];
        a    = regs[word[RJ_LSB +: REG_AW]];
        b    = regs[word[RK_LSB +: REG_AW]];
        imm  = {{(XLEN-12){word[IMM_LSB+11]}}, word[IMM_LSB +: 12]};
        slot = csr_slot(word[CSR_LSB +: CSR_AW]);
        we   = 1'b1;
        res  = '0;
        case (opcode_e'(opc))
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL:   res = a << b[4:0];
            OP_SRL:   res = a >> b[4:0];
            OP_ADDI:  res = a + imm;
            OP_CSRRD: res = (slot < 0) ? '0 : csrs[slot];
            OP_CSRWR, OP_CSRXCHG: begin
                // exchange only touches bits set in rj
                mask = (opcode_e'(opc) == OP_CSRXCHG) ? a : '1;
                if (slot >= 0) begin
                    res = csrs[slot];
                    mask = mask & wmask_of(slot);
                    csrs[slot] = (res & ~mask) | (regs[rd] & mask);
                end
            end
            default:  we = 1'b0;
        endcase
        if (we && rd != '0) begin
            regs[rd]     = res;
            item.pc      = pc;
            item.num     = rd;
            item.data    = res;
            item.edge_no = edge_cnt;
            exp_q.push_back(item);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (debug_wb_rf_we === 1'b1) begin
                $display("t=%0t write strobe while reset is held", $time);
                err_cnt++;
            end
            reset_model();
        end else begin
            edge_cnt++;
            check_debug();
            if (inst_valid === 1'b1)
                apply_inst(inst, inst_pc);
        end
        depth = exp_q.size();
    end

endmodule

/* tb_mini_core.sv */
`timescale 1ns/100ps

module tb_mini_core
    import core_pkg::*;
();

    localparam int NUM_SAVE    = 4;
    localparam int DRAIN_LIMIT = 20;
    localparam int RUN_LIMIT   = 100000;

    logic              clk;
    logic              rst;
    logic              inst_valid;
    logic [XLEN-1:0]   inst;
    logic [XLEN-1:0]   inst_pc;
    logic              debug_wb_rf_we;
    logic [XLEN-1:0]   debug_wb_pc;
    logic [REG_AW-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]   debug_wb_rf_wdata;
    int                chk_errors;
    int                chk_writes;
    int                chk_pending;
    logic [XLEN-1:0]   pc_next;
    int                exp_writes;
    int                err_start;
    int                wr_start;
    int                exp_start;
    int                tests_run;
    int                tests_failed;
    bit                timed_out;

    mini_core_top #(
        .NUM_SAVE (NUM_SAVE)
    ) uut (
        .clk               (clk),
        .rst               (rst),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .inst_pc           (inst_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    core_checker #(
        .NUM_SAVE (NUM_SAVE)
    ) chk (
        .clk               (clk),
        .rst               (rst),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .inst_pc           (inst_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .errors            (chk_errors),
        .writes            (chk_writes),
        .pending           (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(RUN_LIMIT);
        $display("simulation ran past %0d ns without finishing", RUN_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [XLEN-1:0] enc_reg(input opcode_e op, input logic [REG_AW-1:0] rd,
                                                input logic [REG_AW-1:0] rj,
                                                input logic [REG_AW-1:0] rk);
        logic [XLEN-1:0] w;
        w = '0;
        w[OPC_LSB +: OPC_W] = op;
        w[RD_LSB +: REG_AW] = rd;
        w[RJ_LSB +: REG_AW] = rj;
        w[RK_LSB +: REG_AW] = rk;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] enc_imm(input opcode_e op, input logic [REG_AW-1:0] rd,
                                                input logic [REG_AW-1:0] rj,
                                                input logic [11:0] imm);
        logic [XLEN-1:0] w;
        w = enc_reg(op, rd, rj, '0);
        w[IMM_LSB +: 12] = imm;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] enc_csr(input opcode_e op, input logic [REG_AW-1:0] rd,
                                                input logic [REG_AW-1:0] rj,
                                                input logic [CSR_AW-1:0] num);
        logic [XLEN-1:0] w;
        w = enc_reg(op, rd, rj, '0);
        w[CSR_LSB +: CSR_AW] = num;
        return w;
    endfunction

    // three picks in four land in r0..r7
    function automatic logic [REG_AW-1:0] pick_reg();
        if ($urandom_range(3, 0) != 0)
            return REG_AW'($urandom_range(7, 0));
        return REG_AW'($urandom_range(31, 0));
    endfunction

    function automatic logic [CSR_AW-1:0] pick_csr();
        case ($urandom_range(5, 0))
            0:       return CSR_CRMD;
            1:       return CSR_PRMD;
            2:       return CSR_ERA;
            3:       return CSR_SAVE_BASE + CSR_AW'(NUM_SAVE);
            4:       return CSR_AW'($urandom_range(15, 2));
            default: return CSR_SAVE_BASE + CSR_AW'($urandom_range(NUM_SAVE - 1, 0));
        endcase
    endfunction

    function automatic opcode_e pick_alu_op();
        return opcode_e'(OPC_W'($urandom_range(8, 1)));
    endfunction

    task automatic issue(input logic [XLEN-1:0] word);
        inst_valid = 1'b1;
        inst       = word;
        inst_pc    = pc_next;
        pc_next    = pc_next + 32'd4;
        // opcodes 1 to 12 write rd unless rd is r0
        if (word[OPC_LSB +: OPC_W] >= 6'd1 && word[OPC_LSB +: OPC_W] <= 6'd12
                && word[RD_LSB +: REG_AW] != '0)
            exp_writes++;
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            inst_valid = 1'b0;
            inst       = $urandom;
            inst_pc    = $urandom;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_test();
        err_start = chk_errors;
        wr_start  = chk_writes;
        exp_start = exp_writes;
    endtask

    task automatic finish_test(input string name);
        int waited;
        int errs;
        int seen;
        int want;
        waited = 0;
        inst_valid = 1'b0;
        while (chk_pending != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (chk_pending != 0) begin
            $display("test %s timed out with %0d writes still pending", name, chk_pending);
            timed_out = 1'b1;
        end
        // flush anything still in flight
        idle(3);
        errs = chk_errors - err_start;
        seen = chk_writes - wr_start;
        want = exp_writes - exp_start;
        tests_run++;
        if (errs == 0 && seen == want && !timed_out) begin
            $display("test %s ok, %0d writes", name, seen);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors, %0d writes seen, %0d expected",
                     name, errs, seen, want);
        end
    endtask

    task automatic test_reset();
        start_test();
        idle(3);
        for (int k = 1; k < 32; k++)
            issue(enc_reg(OP_ADD, REG_AW'(k), REG_AW'(k), REG_AW'(k)));
        issue(enc_csr(OP_CSRRD, 5'd1, 5'd0, CSR_CRMD));
        finish_test("reset");
    endtask

    task automatic test_alu_stream();
        start_test();
        for (int k = 1; k < 8; k++)
            issue(enc_imm(OP_ADDI, REG_AW'(k), 5'd0, 12'($urandom)));
        for (int n = 0; n < 200; n++)
            issue(enc_reg(pick_alu_op(), pick_reg(), pick_reg(), pick_reg()));
        finish_test("alu_stream");
    endtask

    task automatic test_addi();
        start_test();
        issue(enc_imm(OP_ADDI, 5'd1, 5'd0, 12'h7ff));
        issue(enc_imm(OP_ADDI, 5'd2, 5'd1, 12'h800));
        for (int n = 0; n < 100; n++)
            issue(enc_imm(OP_ADDI, pick_reg(), pick_reg(), 12'($urandom)));
        finish_test("addi");
    endtask

    task automatic test_csr();
        start_test();
        issue(enc_imm(OP_ADDI, 5'd3, 5'd0, 12'hfff));
        issue(enc_imm(OP_ADDI, 5'd5, 5'd0, 12'h00c));
        issue(enc_csr(OP_CSRWR, 5'd3, 5'd0, CSR_CRMD));
        issue(enc_csr(OP_CSRRD, 5'd4, 5'd0, CSR_CRMD));
        issue(enc_imm(OP_ADDI, 5'd6, 5'd0, 12'hfff));
        issue(enc_csr(OP_CSRXCHG, 5'd6, 5'd5, CSR_PRMD));
        issue(enc_csr(OP_CSRRD, 5'd7, 5'd0, CSR_PRMD));
        for (int n = 0; n < 150; n++) begin
            case ($urandom_range(3, 0))
                0:       issue(enc_imm(OP_ADDI, pick_reg(), pick_reg(), 12'($urandom)));
                1:       issue(enc_csr(OP_CSRRD, pick_reg(), pick_reg(), pick_csr()));
                2:       issue(enc_csr(OP_CSRWR, pick_reg(), pick_reg(), pick_csr()));
                default: issue(enc_csr(OP_CSRXCHG, pick_reg(), pick_reg(), pick_csr()));
            endcase
        end
        for (int s = 0; s < NUM_SAVE; s++)
            issue(enc_csr(OP_CSRRD, REG_AW'(s + 1), 5'd0, CSR_SAVE_BASE + CSR_AW'(s)));
        issue(enc_csr(OP_CSRRD, 5'd8, 5'd0, 14'h3ff));
        finish_test("csr");
    endtask

    task automatic test_suppressed();
        start_test();
        for (int n = 0; n < 40; n++) begin
            case ($urandom_range(3, 0))
                0:       issue(enc_reg(pick_alu_op(), 5'd0, pick_reg(), pick_reg()));
                1:       issue(enc_imm(OP_NOP, pick_reg(), pick_reg(), 12'($urandom)));
                2:       issue({OPC_W'($urandom_range(63, 13)), 26'($urandom)});
                default: idle(1);
            endcase
        end
        issue(enc_reg(OP_ADD, 5'd1, 5'd0, 5'd0));
        issue(enc_imm(OP_ADDI, 5'd2, 5'd0, 12'h005));
        finish_test("suppressed");
    endtask

    task automatic test_latency();
        start_test();
        for (int n = 0; n < 30; n++) begin
            issue(enc_reg(pick_alu_op(), REG_AW'($urandom_range(31, 1)), pick_reg(), pick_reg()));
            idle($urandom_range(3, 0));
        end
        finish_test("latency");
    endtask

    initial begin
        void'($urandom(32'ha3b5d928));
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        inst_pc      = '0;
        pc_next      = 32'h0000_1000;
        exp_writes   = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        if (!timed_out)
            test_alu_stream();
        if (!timed_out)
            test_addi();
        if (!timed_out)
            test_csr();
        if (!timed_out)
            test_suppressed();
        if (!timed_out)
            test_latency();
        $display("summary: %0d tests, %0d failed, %0d checker errors, %0d writes checked",
                 tests_run, tests_failed, chk_errors, chk_writes);
        if (tests_failed == 0 && chk_errors == 0 && !timed_out)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* mini_core_top.f */
core_pkg.sv
alu_exec.sv
csr_file.sv
issue_stage.sv
writeback_stage.sv
mini_core_top.sv
core_checker.sv
tb_mini_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= mini_core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
